/* logic/issuePkg.sv */
package issuePkg;

    // instruction word and field widths
    localparam int INST_W = 16;
    localparam int OPC_W = 5;
    localparam int REG_W = 3;

    // opcode group prefix, upper bits of the opcode
    localparam int GRP_W = 3;

    // low bit of each register field
    localparam int RS_LO = 8;
    localparam int RT_LO = 5;
    localparam int RD_LO = 2;

    // jal/jalr link register
    localparam logic [REG_W-1:0] LINK_REG = 3'd7;

    // special and jump opcodes
    localparam logic [OPC_W-1:0] OPC_HALT = 5'b00000;
    localparam logic [OPC_W-1:0] OPC_NOP = 5'b00001;
    localparam logic [OPC_W-1:0] OPC_SIIC = 5'b00010;
    localparam logic [OPC_W-1:0] OPC_RTI = 5'b00011;
    localparam logic [OPC_W-1:0] OPC_J = 5'b00100;
    localparam logic [OPC_W-1:0] OPC_JR = 5'b00101;
    localparam logic [OPC_W-1:0] OPC_JAL = 5'b00110;
    localparam logic [OPC_W-1:0] OPC_JALR = 5'b00111;

    // memory and load-immediate opcodes
    localparam logic [OPC_W-1:0] OPC_ST = 5'b10000;
    localparam logic [OPC_W-1:0] OPC_LD = 5'b10001;
    localparam logic [OPC_W-1:0] OPC_SLBI = 5'b10010;
    localparam logic [OPC_W-1:0] OPC_STU = 5'b10011;
    localparam logic [OPC_W-1:0] OPC_LBI = 5'b11000;

    // R-format alu opcodes
    localparam logic [OPC_W-1:0] OPC_BITOP = 5'b11010;
    localparam logic [OPC_W-1:0] OPC_ARITH = 5'b11011;

    // wildcard groups, matched on the upper three opcode bits
    // branch 011xx, set 111xx, immediates 010xx and 101xx
    localparam logic [GRP_W-1:0] GRP_BRANCH = 3'b011;
    localparam logic [GRP_W-1:0] GRP_SET = 3'b111;
    localparam logic [GRP_W-1:0] GRP_IMM_ARITH = 3'b010;
    localparam logic [GRP_W-1:0] GRP_IMM_LOGIC = 3'b101;

    // bubble, nop opcode with all-zero operands
    localparam logic [INST_W-1:0] NOP_INST = {OPC_NOP, {(INST_W-OPC_W){1'b0}}};

    // which register fields an instruction reads
    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_RS,
        CLS_RS_RD,
        CLS_RS_RT,
        CLS_HALT
    } instClassE;

    // issue runs until a halt fires
    typedef enum logic {
        ISSUE_RUN,
        ISSUE_HALTED
    } issueStateE;

endpackage

/* logic/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf import issuePkg::*; ();

    // source operands of the held instruction
    logic             readsRs;
    logic [REG_W-1:0] rsAddr;
    // bits 7..5, store data or R-format rt
    logic             readsRt;
    logic [REG_W-1:0] rtAddr;

    // destination
    logic             writes;
    logic [REG_W-1:0] wrtReg;

    // branch or jump, and halt
    logic             isCtrl;
    logic             isHalt;

    modport dec (
        output readsRs, rsAddr, readsRt, rtAddr,
        output writes, wrtReg, isCtrl, isHalt
    );

    // hazard unit and tracker only look
    modport user (
        input readsRs, rsAddr, readsRt, rtAddr,
        input writes, wrtReg, isCtrl, isHalt
    );

endinterface

/* logic/instDecode.sv */
`timescale 1ns/1ps

module instDecode import issuePkg::*; (
    input  logic [INST_W-1:0] heldInst,
    input  logic              heldValid,
    decodeIf.dec              dec
);

    logic [OPC_W-1:0] opcode;
    logic [GRP_W-1:0] opGroup;
    instClassE        instClass;
    logic             wrtEn;
    logic [REG_W-1:0] wrtDest;
    logic             ctrl;

    assign opcode = heldInst[INST_W-1 -: OPC_W];
    assign opGroup = opcode[OPC_W-1 -: GRP_W];

    // classify by opcode, wildcard groups first
    always_comb begin
        instClass = CLS_NONE;
        wrtEn = 1'b0;
        wrtDest = '0;
        ctrl = 1'b0;
        if (opGroup == GRP_BRANCH) begin
            // branch on rs, resolves in mem
            instClass = CLS_RS;
            ctrl = 1'b1;
        end else if (opGroup == GRP_SET) begin
            instClass = CLS_RS_RT;
            wrtEn = 1'b1;
            wrtDest = heldInst[RD_LO +: REG_W];
        end else if (opGroup == GRP_IMM_ARITH || opGroup == GRP_IMM_LOGIC) begin
            // I-format, result into bits 7..5
            instClass = CLS_RS;
            wrtEn = 1'b1;
            wrtDest = heldInst[RT_LO +: REG_W];
        end else begin
            case (opcode)
                OPC_HALT: instClass = CLS_HALT;
                OPC_NOP, OPC_SIIC, OPC_RTI: instClass = CLS_NONE;
                OPC_J: ctrl = 1'b1;
                OPC_JR: begin
                    instClass = CLS_RS;
                    ctrl = 1'b1;
                end
                OPC_JAL: begin
                    ctrl = 1'b1;
                    wrtEn = 1'b1;
                    wrtDest = LINK_REG;
                end
                OPC_JALR: begin
                    instClass = CLS_RS;
                    ctrl = 1'b1;
                    wrtEn = 1'b1;
                    wrtDest = LINK_REG;
                end
                // store reads its data register, writes nothing
                OPC_ST: instClass = CLS_RS_RD;
                // stu also writes the updated base back
                OPC_STU: begin
                    instClass = CLS_RS_RD;
                    wrtEn = 1'b1;
                    wrtDest = heldInst[RS_LO +: REG_W];
                end
                OPC_LD: begin
                    instClass = CLS_RS;
                    wrtEn = 1'b1;
                    wrtDest = heldInst[RT_LO +: REG_W];
                end
                // slbi shifts rs in place
                OPC_SLBI: begin
                    instClass = CLS_RS;
                    wrtEn = 1'b1;
                    wrtDest = heldInst[RS_LO +: REG_W];
                end
                OPC_LBI: begin
                    wrtEn = 1'b1;
                    wrtDest = heldInst[RS_LO +: REG_W];
                end
                OPC_BITOP, OPC_ARITH: begin
                    instClass = CLS_RS_RT;
                    wrtEn = 1'b1;
                    wrtDest = heldInst[RD_LO +: REG_W];
                end
                // remaining R-format (btr) reads only rs
                default: begin
                    instClass = CLS_RS;
                    wrtEn = 1'b1;
                    wrtDest = heldInst[RD_LO +: REG_W];
                end
            endcase
        end
    end

    // empty holding register decodes to nothing
    assign dec.readsRs = heldValid && (instClass inside {CLS_RS, CLS_RS_RD, CLS_RS_RT});
    assign dec.readsRt = heldValid && (instClass inside {CLS_RS_RD, CLS_RS_RT});
    assign dec.rsAddr = heldValid ? heldInst[RS_LO +: REG_W] : '0;
    assign dec.rtAddr = heldValid ? heldInst[RT_LO +: REG_W] : '0;
    assign dec.writes = heldValid && wrtEn;
    assign dec.wrtReg = heldValid ? wrtDest : '0;
    assign dec.isCtrl = heldValid && ctrl;
    assign dec.isHalt = heldValid && (instClass == CLS_HALT);

endmodule

/* logic/hazardDetect.sv */
`timescale 1ns/1ps

module hazardDetect import issuePkg::*; #(
    parameter int TRACK_DEPTH = 3
) (
    decodeIf.user                           dec,
    input  logic [TRACK_DEPTH-1:0]            trkWrt,
    input  logic [TRACK_DEPTH-1:0][REG_W-1:0] trkReg,
    input  logic [TRACK_DEPTH-1:0]            trkCtrl,
    output logic                              stall
);

    // per-stage source matches
    logic [TRACK_DEPTH-1:0] rsHit;
    logic [TRACK_DEPTH-1:0] rtHit;
    logic                   rawHazard;
    logic                   ctrlHazard;

    // compare each source against every in-flight write
    // writeback is not in the window, regfile writes before read
    always_comb begin
        for (int i = 0; i < TRACK_DEPTH; i++) begin
            rsHit[i] = dec.readsRs && trkWrt[i] && (trkReg[i] == dec.rsAddr);
            rtHit[i] = dec.readsRt && trkWrt[i] && (trkReg[i] == dec.rtAddr);
        end
    end

    // any stage producing a register we read
    assign rawHazard = (|rsHit) | (|rtHit);

    // branches resolve in mem, so hold everything
    // until the transfer has left the window
    assign ctrlHazard = |trkCtrl;

    assign stall = rawHazard | ctrlHazard;

endmodule

/* logic/pipeTracker.sv */
`timescale 1ns/1ps

module pipeTracker import issuePkg::*; #(
    parameter int TRACK_DEPTH = 3
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              issueFire,
    decodeIf.user                           dec,
    output logic [TRACK_DEPTH-1:0]            trkWrt,
    output logic [TRACK_DEPTH-1:0][REG_W-1:0] trkReg,
    output logic [TRACK_DEPTH-1:0]            trkCtrl
);

    // entry for stage 0, empty on a bubble
    logic             newWrt;
    logic [REG_W-1:0] newReg;
    logic             newCtrl;

    assign newWrt = issueFire && dec.writes;
    assign newReg = issueFire ? dec.wrtReg : '0;
    assign newCtrl = issueFire && dec.isCtrl;

    // stage 0 = decode, shifts every cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            trkWrt <= '0;
            trkReg <= '0;
            trkCtrl <= '0;
        end else begin
            trkWrt[0] <= newWrt;
            trkReg[0] <= newReg;
            trkCtrl[0] <= newCtrl;
            // older stages move one step on
            for (int i = 1; i < TRACK_DEPTH; i++) begin
                trkWrt[i] <= trkWrt[i-1];
                trkReg[i] <= trkReg[i-1];
                trkCtrl[i] <= trkCtrl[i-1];
            end
        end
    end

endmodule

/* logic/issueStage.sv */
`timescale 1ns/1ps

module issueStage import issuePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instValid,
    input  logic [INST_W-1:0] instData,
    output logic              instReady,
    input  logic              stall,
    input  logic              isHalt,
    output logic [INST_W-1:0] heldInst,
    output logic              heldValid,
    output logic              issueFire,
    output logic [INST_W-1:0] issueInst,
    output logic              halted
);

    issueStateE state;
    logic       running;
    logic       accept;

    assign running = (state == ISSUE_RUN);

    // held instruction leaves this cycle
    assign issueFire = heldValid && !stall && running;

    // room when empty or draining, never after halt
    // held low through reset
    assign instReady = rstN && running && (!heldValid || issueFire);
    assign accept = instValid && instReady;

    // one-entry holding register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            heldValid <= 1'b0;
        end else if (accept) begin
            heldValid <= 1'b1;
        end else if (issueFire) begin
            heldValid <= 1'b0;
        end
    end

    // payload only, qualified by heldValid
    always_ff @(posedge clk) begin
        if (accept) begin
            heldInst <= instData;
        end
    end

    // issue slot, bubble on every cycle without a fire
    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueInst <= NOP_INST;
        end else begin
            issueInst <= issueFire ? heldInst : NOP_INST;
        end
    end

    // halt goes out once, then issue freezes until reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= ISSUE_RUN;
        end else if (issueFire && isHalt) begin
            state <= ISSUE_HALTED;
        end
    end

    assign halted = (state == ISSUE_HALTED);

endmodule

/* logic/issueCtrlTop.sv */
`timescale 1ns/1ps

module issueCtrlTop import issuePkg::*; #(
    parameter int TRACK_DEPTH = 3
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instValid,
    input  logic [INST_W-1:0] instData,
    output logic              instReady,
    output logic [INST_W-1:0] issueInst,
    output logic              halted
);

    // decoded view of the held instruction
    decodeIf decBus ();

    // holding register to decoder
    logic [INST_W-1:0] heldInst;
    logic              heldValid;

    // issue strobe and stall
    logic issueFire;
    logic stall;

    // in-flight status, stage 0 is decode
    logic [TRACK_DEPTH-1:0]            trkWrt;
    logic [TRACK_DEPTH-1:0][REG_W-1:0] trkReg;
    logic [TRACK_DEPTH-1:0]            trkCtrl;

    issueStage i_issueStage (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instData  (instData),
        .instReady (instReady),
        .stall     (stall),
        .isHalt    (decBus.isHalt),
        .heldInst  (heldInst),
        .heldValid (heldValid),
        .issueFire (issueFire),
        .issueInst (issueInst),
        .halted    (halted)
    );

    instDecode i_instDecode (
        .heldInst  (heldInst),
        .heldValid (heldValid),
        .dec       (decBus.dec)
    );

    hazardDetect #(.TRACK_DEPTH(TRACK_DEPTH)) i_hazardDetect (
        .dec     (decBus.user),
        .trkWrt  (trkWrt),
        .trkReg  (trkReg),
        .trkCtrl (trkCtrl),
        .stall   (stall)
    );

    pipeTracker #(.TRACK_DEPTH(TRACK_DEPTH)) i_pipeTracker (
        .clk       (clk),
        .rstN      (rstN),
        .issueFire (issueFire),
        .dec       (decBus.user),
        .trkWrt    (trkWrt),
        .trkReg    (trkReg),
        .trkCtrl   (trkCtrl)
    );

endmodule

/* sim/issueCtrlTb.sv */
`timescale 1ns/1ps

module issueCtrlTb import issuePkg::*; ();

    localparam int TRACK_DEPTH = 3;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INST = 2000;
    localparam int NUM_RANDOM = 1800;
    // worst case one fire every 4 cycles
    localparam int MAX_CYCLES = RESET_CYCLES + 4 * NUM_INST + 200;
    localparam logic [31:0] SEED = 32'he5081bb8;

    // what the model needs from one instruction
    typedef struct packed {
        logic             readsRs;
        logic             readsRt;
        logic             wrt;
        logic [REG_W-1:0] dst;
        logic             ctrl;
        logic             halt;
    } decodeT;

    typedef struct packed {
        logic              fire;
        decodeT            dec;
        logic [INST_W-1:0] nextInst;
    } stepT;

    logic              clk;
    logic              rstN;
    logic              instValid;
    logic [INST_W-1:0] instData;
    logic              instReady;
    logic [INST_W-1:0] issueInst;
    logic              halted;

    // reference model state
    logic [INST_W-1:0]                 mHeld;
    logic                              mHeldValid;
    logic [TRACK_DEPTH-1:0]            mTrkWrt;
    logic [TRACK_DEPTH-1:0][REG_W-1:0] mTrkReg;
    logic [TRACK_DEPTH-1:0]            mTrkCtrl;
    logic                              mHalted;
    logic [INST_W-1:0]                 mIssue;
    logic                              modelLive = 1'b0;
    int                                cycleCount = 0;
    int                                seedDiscard;

    issueCtrlTop #(.TRACK_DEPTH(TRACK_DEPTH)) i_issueCtrlTop (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instData  (instData),
        .instReady (instReady),
        .issueInst (issueInst),
        .halted    (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // register use per format from the opcode table
    function automatic decodeT decodeRef(input logic [INST_W-1:0] inst);
        decodeT           d;
        logic [OPC_W-1:0] opc;
        logic             rForm;
        opc = inst[15:11];
        rForm = (opc[4:2] == 3'b111) || (opc inside {OPC_BITOP, OPC_ARITH, 5'b11001});
        d = '0;
        d.readsRs = !(opc inside {OPC_HALT, OPC_NOP, OPC_SIIC, OPC_RTI, OPC_J, OPC_JAL, OPC_LBI});
        d.readsRt = (opc[4:2] == 3'b111) || (opc inside {OPC_ST, OPC_STU, OPC_BITOP, OPC_ARITH});
        d.ctrl = (opc[4:2] == 3'b011) || (opc inside {OPC_J, OPC_JR, OPC_JAL, OPC_JALR});
        d.halt = (opc == OPC_HALT);
        d.wrt = 1'b1;
        if (rForm)
            d.dst = inst[4:2];
        else if (opc == OPC_LD || opc[4:2] == 3'b010 || opc[4:2] == 3'b101)
            d.dst = inst[7:5];
        else if (opc inside {OPC_LBI, OPC_SLBI, OPC_STU})
            d.dst = inst[10:8];
        else if (opc inside {OPC_JAL, OPC_JALR})
            d.dst = 3'd7;
        else
            d.wrt = 1'b0;
        return d;
    endfunction

    // fire decision and next issue slot for one cycle
    function automatic stepT stepModel(
        input logic [INST_W-1:0]                 held,
        input logic                              heldValid,
        input logic [TRACK_DEPTH-1:0]            trkWrt,
        input logic [TRACK_DEPTH-1:0][REG_W-1:0] trkReg,
        input logic [TRACK_DEPTH-1:0]            trkCtrl,
        input logic                              isHalted
    );
        stepT s;
        logic hazard;
        s.dec = decodeRef(held);
        hazard = 1'b0;
        for (int i = 0; i < TRACK_DEPTH; i++) begin
            if (trkCtrl[i])
                hazard = 1'b1;
            if (trkWrt[i] && s.dec.readsRs && trkReg[i] == held[10:8])
                hazard = 1'b1;
            if (trkWrt[i] && s.dec.readsRt && trkReg[i] == held[7:5])
                hazard = 1'b1;
        end
        s.fire = heldValid && !hazard && !isHalted;
        s.nextInst = s.fire ? held : NOP_INST;
        return s;
    endfunction

    // model advances on every rising edge
    always @(posedge clk) begin : refModel
        stepT s;
        logic ready;
        if (!rstN) begin
            mHeldValid = 1'b0;
            mTrkWrt = '0;
            mTrkReg = '0;
            mTrkCtrl = '0;
            mHalted = 1'b0;
            mIssue = NOP_INST;
            modelLive = 1'b1;
        end else if (modelLive) begin
            s = stepModel(mHeld, mHeldValid, mTrkWrt, mTrkReg, mTrkCtrl, mHalted);
            ready = !mHalted && (!mHeldValid || s.fire);
            mIssue = s.nextInst;
            mTrkWrt = {mTrkWrt[TRACK_DEPTH-2:0], s.fire && s.dec.wrt};
            mTrkReg = {mTrkReg[TRACK_DEPTH-2:0], s.dec.dst};
            mTrkCtrl = {mTrkCtrl[TRACK_DEPTH-2:0], s.fire && s.dec.ctrl};
            if (s.fire && s.dec.halt)
                mHalted = 1'b1;
            if (instValid && ready) begin
                mHeld = instData;
                mHeldValid = 1'b1;
            end else if (s.fire) begin
                mHeldValid = 1'b0;
            end
        end
    end

    task automatic checkInst(
        input string             name,
        input logic [INST_W-1:0] actual,
        input logic [INST_W-1:0] expected
    );
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // outputs settle a quarter period after the edge
    always @(posedge clk) begin : compare
        stepT s;
        #(CLK_PERIOD / 4);
        if (modelLive) begin
            s = stepModel(mHeld, mHeldValid, mTrkWrt, mTrkReg, mTrkCtrl, mHalted);
            checkInst("issueInst", issueInst, mIssue);
            checkFlag("halted", halted, mHalted);
            checkFlag("instReady", instReady, rstN && !mHalted && (!mHeldValid || s.fire));
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        instValid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
    endtask

    // offer one word after a gap and hold it until taken
    task automatic sendInst(input logic [INST_W-1:0] inst, input int gap);
        logic taken;
        if (gap > 0) begin
            instValid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        instValid = 1'b1;
        instData = inst;
        taken = 1'b0;
        while (!taken) begin
            // ready does not depend on valid so the mid-cycle value holds at the edge
            #(CLK_PERIOD / 4);
            taken = instReady;
            @(negedge clk);
        end
    endtask

    // wait until nothing is held or in flight
    task automatic drain();
        instValid = 1'b0;
        while (mHeldValid || (|mTrkWrt) || (|mTrkCtrl))
            @(negedge clk);
        @(negedge clk);
    endtask

    function automatic logic [INST_W-1:0] makeInst(
        input logic [OPC_W-1:0] opc,
        input logic [REG_W-1:0] rs,
        input logic [REG_W-1:0] rt,
        input logic [REG_W-1:0] rd
    );
        return {opc, rs, rt, rd, 2'b00};
    endfunction

    // mostly r0..r3 so dependencies are frequent
    function automatic logic [REG_W-1:0] randReg();
        if ($urandom_range(7) == 0)
            return REG_W'($urandom_range(7));
        return REG_W'($urandom_range(3));
    endfunction

    // no halt in random traffic
    function automatic logic [INST_W-1:0] randInst();
        logic [OPC_W-1:0] opc;
        opc = OPC_W'($urandom_range(31));
        if (opc == OPC_HALT)
            opc = OPC_NOP;
        return {opc, randReg(), randReg(), randReg(), 2'($urandom_range(3))};
    endfunction

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instValid = 1'b0;
        instData = '0;
        seedDiscard = $urandom(SEED);
        applyReset();

        // independent words issued back to back
        sendInst(NOP_INST, 0);
        sendInst(makeInst(OPC_SIIC, 0, 0, 0), 0);
        sendInst(makeInst(OPC_LBI, 1, 0, 0), 0);
        sendInst(makeInst(OPC_LBI, 2, 0, 0), 0);
        sendInst(makeInst(OPC_ARITH, 4, 5, 6), 0);
        drain();

        // RAW on rs, rt and store data
        sendInst(makeInst(OPC_LBI, 1, 0, 0), 0);
        sendInst(makeInst(OPC_ARITH, 1, 4, 5), 0);
        sendInst(makeInst(OPC_LBI, 2, 0, 0), 0);
        sendInst(makeInst(OPC_ARITH, 4, 2, 5), 0);
        sendInst(makeInst(OPC_LBI, 3, 0, 0), 0);
        sendInst(makeInst(OPC_ST, 0, 3, 0), 0);
        drain();

        // only the named destination field stalls a consumer
        sendInst(makeInst(OPC_ARITH, 4, 5, 6), 0);
        sendInst(makeInst(OPC_LD, 5, 0, 0), 0);
        sendInst(makeInst(OPC_BITOP, 6, 0, 1), 0);
        sendInst(makeInst(5'b01000, 1, 2, 0), 0);
        sendInst(makeInst(OPC_LD, 1, 3, 0), 0);
        sendInst(makeInst(OPC_ARITH, 0, 2, 4), 0);
        sendInst(makeInst(OPC_SLBI, 3, 0, 0), 0);
        sendInst(makeInst(OPC_ARITH, 3, 0, 0), 0);
        sendInst(makeInst(OPC_STU, 5, 1, 0), 0);
        sendInst(makeInst(OPC_LD, 1, 6, 0), 0);
        sendInst(makeInst(OPC_ARITH, 5, 0, 0), 0);
        sendInst(makeInst(OPC_JAL, 0, 0, 0), 0);
        sendInst(makeInst(OPC_ARITH, 7, 0, 1), 0);
        sendInst(makeInst(OPC_JALR, 2, 0, 0), 0);
        drain();

        // control transfers and a branch held on its rs
        sendInst(makeInst(5'b01100, 0, 0, 0), 0);
        sendInst(makeInst(OPC_LBI, 1, 0, 0), 0);
        sendInst(makeInst(OPC_J, 0, 0, 0), 0);
        sendInst(NOP_INST, 0);
        sendInst(makeInst(OPC_LBI, 2, 0, 0), 0);
        sendInst(makeInst(5'b01101, 2, 0, 0), 0);
        sendInst(makeInst(OPC_JR, 3, 0, 0), 0);
        sendInst(makeInst(OPC_LBI, 6, 0, 0), 0);
        drain();

        // mixed traffic with random valid gaps
        for (int n = 0; n < NUM_RANDOM; n++)
            sendInst(randInst(), ($urandom_range(3) == 0) ? $urandom_range(2, 1) : 0);
        drain();

        // halt with nothing queued behind it
        sendInst(makeInst(OPC_HALT, 0, 0, 0), 0);
        instValid = 1'b0;
        while (!mHalted)
            @(negedge clk);
        // holding register is empty so only the halt keeps this word out
        instValid = 1'b1;
        instData = makeInst(OPC_LBI, 1, 0, 0);
        repeat (4) @(negedge clk);
        checkFlag("halted", halted, 1'b1);
        checkFlag("instReady", instReady, 1'b0);
        checkInst("issueInst", issueInst, NOP_INST);

        // second reset brings issue back
        applyReset();
        sendInst(makeInst(OPC_LBI, 3, 0, 0), 0);
        sendInst(makeInst(OPC_ARITH, 0, 1, 2), 0);
        drain();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* build.f */
logic/issuePkg.sv
logic/decodeIf.sv
logic/instDecode.sv
logic/hazardDetect.sv
logic/pipeTracker.sv
logic/issueStage.sv
logic/issueCtrlTop.sv
sim/issueCtrlTb.sv

/* Bender.yml */
package:
  name: issueCtrl

sources:
  - logic/issuePkg.sv
  - logic/decodeIf.sv
  - logic/instDecode.sv
  - logic/hazardDetect.sv
  - logic/pipeTracker.sv
  - logic/issueStage.sv
  - logic/issueCtrlTop.sv
  - target: simulation
    files:
      - sim/issueCtrlTb.sv
